// ==== build.f ====
+incdir+include
logic/mul_pkg.sv
logic/mul_req_if.sv
logic/booth_pp_gen.sv
logic/csa_tree.sv
logic/brent_kung_adder.sv
logic/booth_mul_pipe.sv
logic/mul_top.sv
testbench/tb_mul_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the multiplier testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"

verilator --binary --assert -Wno-fatal -f build.f --top-module tb_mul_top \
  && ./obj_dir/Vtb_mul_top > "$log" 2>&1 \
  || echo "build or simulation returned an error"

[ -s "$log" ] || { echo "no simulation log produced"; exit 1; }
cat "$log"

grep -q "SIMULATION FAILED" "$log" && { echo "test failed"; exit 1; } \
  || { echo "test passed"; exit 0; }

// ==== testbench/tb_mul_top.sv ====
// Testbench for the Booth multiplier top level
// Corner and LCG requests against a queue model, checked by assertions
`timescale 1ns/1ns
`default_nettype none

`include "mul_params.svh"

module tb_mul_top;
  import mul_pkg::*;

  localparam int W          = `MUL_WIDTH;
  localparam int N_DIR      = 10;
  localparam int N_RAND     = 240;
  localparam int TOTAL      = N_DIR + N_RAND;
  localparam int MAX_CYCLES = 4 * (TOTAL + 20);

  // Corner operands
  localparam operand_t ZERO     = '0;
  localparam operand_t ONES     = '1;
  localparam operand_t MOST_NEG = operand_t'(1) << (W - 1);

  logic     clk;
  logic     rst_n;
  logic     req_valid;
  logic     req_ready;
  operand_t op_a;
  operand_t op_b;
  logic     a_signed;
  logic     b_signed;
  logic     res_valid;
  logic     res_ready;
  product_t product;

  // Expected products in request order
  product_t    exp_q [$];
  // Expected valid position in the two stages
  logic [1:0]  exp_vq;
  int          consumed = 0;
  int          cycles = 0;
  logic        prev_ready;
  logic        prev_valid;
  product_t    prev_product;
  logic [31:0] rng_state;

  mul_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .op_a      (op_a),
    .op_b      (op_b),
    .a_signed  (a_signed),
    .b_signed  (b_signed),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .product   (product)
  );

  always #20 clk = ~clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////
  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  // Extend each operand by its flag, multiply at full width
  function automatic product_t ref_product(input operand_t a, input operand_t b,
                                           input logic as, input logic bs);
    product_t ax;
    product_t bx;
    ax = {{W{as & a[W-1]}}, a};
    bx = {{W{bs & b[W-1]}}, b};
    return ax * bx;
  endfunction

  // LCG step, upper half of the state as output
  function logic [15:0] rand16();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state[31:16];
  endfunction

  task automatic set_operands(input operand_t a, input operand_t b,
                              input logic as, input logic bs);
    op_a     <= a;
    op_b     <= b;
    a_signed <= as;
    b_signed <= bs;
  endtask

  // Directed corners first, then random requests with valid gaps
  task automatic load_request(input int idx);
    logic [15:0] r;
    if (idx < N_DIR) begin
      req_valid <= 1'b1;
      case (idx)
        0: set_operands(ZERO, ZERO, 1'b0, 1'b0);
        1: set_operands(ONES, ONES, 1'b0, 1'b0);
        2: set_operands(ONES, ONES, 1'b1, 1'b1);
        3: set_operands(MOST_NEG, MOST_NEG, 1'b1, 1'b1);
        4: set_operands(MOST_NEG, ONES, 1'b1, 1'b1);
        5: set_operands(MOST_NEG, ONES, 1'b1, 1'b0);
        6: set_operands(ONES, MOST_NEG, 1'b0, 1'b1);
        7: set_operands(ONES, ZERO, 1'b1, 1'b1);
        8: set_operands(MOST_NEG, MOST_NEG, 1'b0, 1'b0);
        default: set_operands(~MOST_NEG, MOST_NEG, 1'b1, 1'b0);
      endcase
    end else begin
      r = rand16();
      req_valid <= (r[15:14] != 2'b00);
      set_operands(operand_t'({rand16(), rand16()}), operand_t'({rand16(), rand16()}),
                   r[0], r[1]);
    end
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////
  // Upstream ready mirrors downstream ready
  assert property (@(posedge clk) disable iff (!rst_n) req_ready == res_ready)
    else stop_with_error($sformatf("error: req_ready 0x%h expected 0x%h", req_ready, res_ready));

  // No result while in reset
  assert property (@(posedge clk) !rst_n |-> !res_valid)
    else stop_with_error($sformatf("error: res_valid 0x%h expected 0x0 in reset", res_valid));

  always @(posedge clk) begin : check
    if (!rst_n) begin
      exp_vq     <= 2'b00;
      prev_ready <= 1'b1;
    end else begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
        stop_with_error($sformatf("timeout: only %0d of %0d results after %0d cycles",
                                  consumed, TOTAL, cycles));
      end
      // Two edges with res_ready high from request to result
      assert (res_valid == exp_vq[1])
        else stop_with_error($sformatf("error: res_valid 0x%h expected 0x%h",
                                       res_valid, exp_vq[1]));
      // Held outputs across a stalled edge
      if (!prev_ready) begin
        assert (res_valid == prev_valid)
          else stop_with_error($sformatf("error: res_valid 0x%h expected 0x%h in stall",
                                         res_valid, prev_valid));
        assert (product == prev_product)
          else stop_with_error($sformatf("error: product 0x%h expected 0x%h in stall",
                                         product, prev_product));
      end
      if (res_ready) begin
        exp_vq <= {exp_vq[0], req_valid};
      end
      // Consume before push, a result never belongs to this edge's request
      if (res_valid && res_ready) begin
        assert (exp_q.size() > 0)
          else stop_with_error("result came out with no request pending");
        assert (product == exp_q[0])
          else stop_with_error($sformatf("error: product 0x%h expected 0x%h",
                                         product, exp_q[0]));
        void'(exp_q.pop_front());
        consumed <= consumed + 1;
      end
      if (req_valid && res_ready) begin
        exp_q.push_back(ref_product(op_a, op_b, a_signed, b_signed));
      end
      prev_ready   <= res_ready;
      prev_valid   <= res_valid;
      prev_product <= product;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin : drive
    int          sent;
    logic        accepted;
    logic [15:0] r;
    clk       = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    op_a      = '0;
    op_b      = '0;
    a_signed  = 1'b0;
    b_signed  = 1'b0;
    res_ready = 1'b0;
    rng_state = 32'd58;
    sent      = 0;
    repeat (2) @(posedge clk);
    rst_n     <= 1'b1;
    res_ready <= 1'b1;
    // Idle edges, res_valid must stay low
    repeat (3) @(posedge clk);
    while (consumed < TOTAL) begin
      @(posedge clk);
      accepted = req_valid && res_ready;
      if (accepted) begin
        sent++;
      end
      // Hold a request not yet taken
      if (!(req_valid && !accepted)) begin
        if (sent < TOTAL) begin
          load_request(sent);
        end else begin
          req_valid <= 1'b0;
        end
      end
      // Corners run back to back, then random stalls
      r = rand16();
      res_ready <= (sent < N_DIR) || (r[15:14] != 2'b00);
    end
    res_ready <= 1'b1;
    repeat (4) @(posedge clk);
    if (exp_q.size() == 0 && consumed == TOTAL) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      stop_with_error("results missing or left over at the end of the run");
    end
  end

endmodule

`default_nettype wire

// ==== logic/mul_top.sv ====
// Booth multiplier top level
// Plain ports into the request bus, level-based flow control
`timescale 1ns/1ns
`default_nettype none

module mul_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid,
  output logic              req_ready,
  input  mul_pkg::operand_t op_a,
  input  mul_pkg::operand_t op_b,
  input  logic              a_signed,
  input  logic              b_signed,
  output logic              res_valid,
  input  logic              res_ready,
  output mul_pkg::product_t product
);

  // Request bus into the pipeline
  mul_req_if req_bus ();

  assign req_bus.op_a     = op_a;
  assign req_bus.op_b     = op_b;
  assign req_bus.a_signed = a_signed;
  assign req_bus.b_signed = b_signed;
  assign req_bus.valid    = req_valid;

  // Source may load exactly when the pipeline advances
  assign req_ready = res_ready;

  booth_mul_pipe u_pipe (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req_bus.sink),
    .res_ready (res_ready),
    .res_valid (res_valid),
    .product   (product)
  );

endmodule

`default_nettype wire

// ==== logic/booth_mul_pipe.sv ====
// Two-stage Booth multiplier pipeline
// Partial products, then carry-save rows, then final prefix add
`timescale 1ns/1ns
`default_nettype none

`include "mul_params.svh"

module booth_mul_pipe (
  input  logic              clk,
  input  logic              rst_n,
  mul_req_if.sink           req,
  input  logic              res_ready,
  output logic              res_valid,
  output mul_pkg::product_t product
);
  import mul_pkg::*;

  // Whole pipeline moves only when downstream takes data
  logic      advance;

  pp_array_t pp_comb;
  pp_array_t pp_q;
  product_t  csa_sum;
  product_t  csa_carry;
  product_t  sum_q;
  product_t  carry_q;
  // Bit 0 tracks stage 1, bit 1 tracks stage 2
  logic [1:0] valid_q;

  assign advance = res_ready;

  //////////////////////////////
  // Valid shifter
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 2'b00;
    end else if (advance) begin
      valid_q <= {valid_q[0], req.valid};
    end
  end

  assign res_valid = valid_q[1];

  //////////////////////////////
  // Stage 1
  //////////////////////////////
  booth_pp_gen u_pp_gen (
    .op_a     (req.op_a),
    .op_b     (req.op_b),
    .a_signed (req.a_signed),
    .b_signed (req.b_signed),
    .pp_rows  (pp_comb)
  );

  // Partial-product array register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `PP_ROWS; i++) begin
        pp_q[i] <= '0;
      end
    end else if (advance) begin
      pp_q <= pp_comb;
    end
  end

  //////////////////////////////
  // Stage 2
  //////////////////////////////
  csa_tree u_csa_tree (
    .pp_rows   (pp_q),
    .sum_row   (csa_sum),
    .carry_row (csa_carry)
  );

  // Carry-save row register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_q   <= '0;
      carry_q <= '0;
    end else if (advance) begin
      sum_q   <= csa_sum;
      carry_q <= csa_carry;
    end
  end

  // Final add, held stable during a stall since its inputs are
  brent_kung_adder u_adder (
    .in_a (sum_q),
    .in_b (carry_q),
    .sum  (product)
  );

endmodule

`default_nettype wire

// ==== logic/brent_kung_adder.sv ====
// Brent-Kung parallel-prefix adder
// Product-width sum of two rows, no carry in or out
`timescale 1ns/1ns
`default_nettype none

`include "mul_params.svh"

module brent_kung_adder (
  input  mul_pkg::product_t in_a,
  input  mul_pkg::product_t in_b,
  output mul_pkg::product_t sum
);
  import mul_pkg::*;

  localparam int N      = `PROD_WIDTH;
  localparam int LOG    = $clog2(`PROD_WIDTH);
  // LOG up-sweep levels then LOG-1 down-sweep levels
  localparam int STAGES = 2 * LOG - 1;

  // Group generate and propagate after each stage
  logic [N-1:0] g_st [STAGES+1];
  logic [N-1:0] p_st [STAGES+1];
  logic [N-1:0] carry;

  //////////////////////////////
  // Bit generate and propagate
  //////////////////////////////
  assign g_st[0] = in_a & in_b;
  assign p_st[0] = in_a ^ in_b;

  //////////////////////////////
  // Prefix tree
  //////////////////////////////
  for (genvar s = 1; s <= STAGES; s++) begin : g_stage
    localparam bit UP   = (s <= LOG);
    // Tree depth index, counts down again on the down-sweep
    localparam int D    = UP ? s - 1 : 2 * LOG - 1 - s;
    localparam int SPAN = 1 << D;

    for (genvar i = 0; i < N; i++) begin : g_bit
      // Up-sweep hits every 2*SPAN-th bit
      // Down-sweep fills the midpoints left open
      localparam bit HIT = UP ? ((i + 1) % (2 * SPAN) == 0)
                              : (((i + 1) % (2 * SPAN) == SPAN) && (i >= 2 * SPAN));

      if (HIT) begin : g_op
        // Black cell, merge with group SPAN bits below
        assign g_st[s][i] = g_st[s-1][i] | (p_st[s-1][i] & g_st[s-1][i-SPAN]);
        assign p_st[s][i] = p_st[s-1][i] & p_st[s-1][i-SPAN];
      end else begin : g_keep
        assign g_st[s][i] = g_st[s-1][i];
        assign p_st[s][i] = p_st[s-1][i];
      end
    end
  end

  //////////////////////////////
  // Sum
  //////////////////////////////
  // Carry into bit i is the prefix generate of bits below it
  assign carry = {g_st[STAGES][N-2:0], 1'b0};
  assign sum   = p_st[0] ^ carry;

endmodule

`default_nettype wire

// ==== logic/csa_tree.sv ====
// Wallace carry-save reduction tree
// Reduces all partial-product rows to a sum row and a carry row
`timescale 1ns/1ns
`default_nettype none

`include "mul_params.svh"

module csa_tree (
  input  mul_pkg::pp_array_t pp_rows,
  output mul_pkg::product_t  sum_row,
  output mul_pkg::product_t  carry_row
);
  import mul_pkg::*;

  // Rows left after one level of 3:2 compression
  function automatic int rows_after(input int n);
    return 2 * (n / 3) + n % 3;
  endfunction

  // Levels needed to get down to two rows
  function automatic int count_levels(input int n);
    int rows;
    int lv;
    rows = n;
    lv = 0;
    while (rows > 2) begin
      rows = rows_after(rows);
      lv++;
    end
    return lv;
  endfunction

  // Row count entering a given level
  function automatic int rows_at(input int lv);
    int rows;
    rows = `PP_ROWS;
    for (int k = 0; k < lv; k++) begin
      rows = rows_after(rows);
    end
    return rows;
  endfunction

  localparam int NUM_LEVELS = count_levels(`PP_ROWS);

  // Row storage per level, upper slots unused once the level shrinks
  product_t lvl [NUM_LEVELS+1][`PP_ROWS];

  for (genvar j = 0; j < `PP_ROWS; j++) begin : g_in
    assign lvl[0][j] = pp_rows[j];
  end

  //////////////////////////////
  // Compression levels
  //////////////////////////////
  for (genvar l = 0; l < NUM_LEVELS; l++) begin : g_level
    localparam int N_IN   = rows_at(l);
    localparam int GROUPS = N_IN / 3;
    localparam int LEFT   = N_IN % 3;
    localparam int N_OUT  = 2 * GROUPS + LEFT;

    // Full adders across whole row width
    for (genvar g = 0; g < GROUPS; g++) begin : g_csa
      product_t a;
      product_t b;
      product_t c;

      assign a = lvl[l][3*g];
      assign b = lvl[l][3*g+1];
      assign c = lvl[l][3*g+2];
      assign lvl[l+1][2*g]   = a ^ b ^ c;
      // Majority moves one bit up, top carry is beyond product width
      assign lvl[l+1][2*g+1] = ((a & b) | (a & c) | (b & c)) << 1;
    end

    // Leftover rows go straight to the next level
    for (genvar k = 0; k < LEFT; k++) begin : g_pass
      assign lvl[l+1][2*GROUPS+k] = lvl[l][3*GROUPS+k];
    end

    for (genvar z = N_OUT; z < `PP_ROWS; z++) begin : g_zero
      assign lvl[l+1][z] = '0;
    end
  end

  assign sum_row   = lvl[NUM_LEVELS][0];
  assign carry_row = lvl[NUM_LEVELS][1];

endmodule

`default_nettype wire

// ==== logic/booth_pp_gen.sv ====
// Radix-4 Booth partial-product generator
// Product-width rows plus negation and sign-extension correction rows
`timescale 1ns/1ns
`default_nettype none

`include "mul_params.svh"

module booth_pp_gen (
  input  mul_pkg::operand_t  op_a,
  input  mul_pkg::operand_t  op_b,
  input  logic               a_signed,
  input  logic               b_signed,
  output mul_pkg::pp_array_t pp_rows
);
  import mul_pkg::*;

  localparam int W          = `MUL_WIDTH;
  localparam int BOOTH_ROWS = W / 2 + 1;
  // Selected multiple is at most 2x a (W+1)-bit signed value
  localparam int ROW_BITS   = W + 2;

  // Each row sign bit is flipped, so subtract 2^(ROW_BITS-1) per row here
  function automatic product_t sign_corr_const();
    product_t acc;
    acc = '0;
    for (int i = 0; i < BOOTH_ROWS; i++) begin
      acc = acc + (product_t'(1) << (ROW_BITS - 1 + 2 * i));
    end
    return ~acc + product_t'(1);
  endfunction

  localparam product_t SIGN_CORR = sign_corr_const();

  //////////////////////////////
  // Operand extension
  //////////////////////////////
  logic                b_top;
  logic                a_top;
  // Multiplier sign-extended to even width, zero below bit 0
  logic [W+2:0]        b_pad;
  logic [W:0]          a_ext;
  logic [ROW_BITS-1:0] a_one;
  logic [ROW_BITS-1:0] a_two;
  logic [BOOTH_ROWS-1:0] neg_bits;
  product_t            neg_row;

  assign b_top = b_signed & op_b[W-1];
  assign a_top = a_signed & op_a[W-1];
  assign b_pad = {b_top, b_top, op_b, 1'b0};
  assign a_ext = {a_top, op_a};
  assign a_one = {a_ext[W], a_ext};
  assign a_two = {a_ext, 1'b0};

  //////////////////////////////
  // Booth rows
  //////////////////////////////
  for (genvar i = 0; i < BOOTH_ROWS; i++) begin : g_row
    logic [2:0]          trip;
    logic                one;
    logic                two;
    logic [ROW_BITS-1:0] mag;
    logic [ROW_BITS-1:0] pat;
    product_t            row_ext;

    // Overlapping triplet b[2i+1], b[2i], b[2i-1]
    assign trip = b_pad[2*i+2 -: 3];

    // Digit magnitude 1 or 2
    assign one = trip[1] ^ trip[0];
    assign two = (trip == 3'b011) | (trip == 3'b100);

    // Negative digits take the inverted multiple
    assign neg_bits[i] = trip[2];

    assign mag = one ? a_one : (two ? a_two : '0);
    assign pat = mag ^ {ROW_BITS{trip[2]}};

    // Flip sign bit, zero above, offset absorbed by SIGN_CORR
    assign row_ext = product_t'({~pat[ROW_BITS-1], pat[ROW_BITS-2:0]});

    // Shift to digit weight, bits beyond product width drop off
    assign pp_rows[i] = row_ext << (2 * i);
  end

  //////////////////////////////
  // Correction rows
  //////////////////////////////
  // The +1 of every negated row, placed at that row's weight
  always_comb begin
    neg_row = '0;
    for (int i = 0; i < BOOTH_ROWS; i++) begin
      neg_row[2*i] = neg_bits[i];
    end
  end

  assign pp_rows[BOOTH_ROWS]     = neg_row;
  assign pp_rows[BOOTH_ROWS + 1] = SIGN_CORR;

endmodule

`default_nettype wire

// ==== logic/mul_req_if.sv ====
// Multiply request bus
// Operands, per-operand signed flags and valid bit
`timescale 1ns/1ns
`default_nettype none

interface mul_req_if;
  import mul_pkg::*;

  // Multiplicand and multiplier
  operand_t op_a;
  operand_t op_b;

  // Treat operand as two's complement when set
  logic     a_signed;
  logic     b_signed;

  // Request present
  logic     valid;

  // Driver side, top level
  modport src (
    output op_a, op_b, a_signed, b_signed, valid
  );

  // Pipeline side
  modport sink (
    input op_a, op_b, a_signed, b_signed, valid
  );

endinterface

`default_nettype wire

// ==== logic/mul_pkg.sv ====
// Multiplier types
// Operand, product and partial-product array vectors
`default_nettype none

`include "mul_params.svh"

package mul_pkg;

  // One input operand
  typedef logic [`MUL_WIDTH-1:0] operand_t;

  // Product sized row, also used for carry-save rows
  typedef logic [`PROD_WIDTH-1:0] product_t;

  // All rows entering the reduction tree
  typedef product_t pp_array_t [`PP_ROWS];

endpackage

`default_nettype wire

// ==== include/mul_params.svh ====
// Multiplier width definitions
// Operand, product and partial-product row counts
`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// Operand width, must be even
`define MUL_WIDTH 16

// Full product width
`define PROD_WIDTH (2 * `MUL_WIDTH)

// Booth rows plus negation row plus sign-extension constant row
`define PP_ROWS (`MUL_WIDTH / 2 + 3)

`endif
